// ==== source/rv_isa_pkg.sv ====
package rv_isa_pkg;

  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [4:0]      reg_addr_t;
  typedef logic [6:0]      opcode_t;
  typedef logic [2:0]      funct3_t;

  // base opcodes, no system or M extension
  localparam opcode_t OPC_LUI    = 7'b0110111;
  localparam opcode_t OPC_AUIPC  = 7'b0010111;
  localparam opcode_t OPC_JAL    = 7'b1101111;
  localparam opcode_t OPC_JALR   = 7'b1100111;
  localparam opcode_t OPC_BRANCH = 7'b1100011;
  localparam opcode_t OPC_LOAD   = 7'b0000011;
  localparam opcode_t OPC_STORE  = 7'b0100011;
  localparam opcode_t OPC_OPIMM  = 7'b0010011;
  localparam opcode_t OPC_OP     = 7'b0110011;

  localparam word_t PC_STEP = word_t'(4);

  // alu funct3
  localparam funct3_t F3_ADD  = 3'b000;
  localparam funct3_t F3_SLL  = 3'b001;
  localparam funct3_t F3_SLT  = 3'b010;
  localparam funct3_t F3_SLTU = 3'b011;
  localparam funct3_t F3_XOR  = 3'b100;
  localparam funct3_t F3_SR   = 3'b101;
  localparam funct3_t F3_OR   = 3'b110;
  localparam funct3_t F3_AND  = 3'b111;

  // branch funct3
  localparam funct3_t F3_BEQ  = 3'b000;
  localparam funct3_t F3_BNE  = 3'b001;
  localparam funct3_t F3_BLT  = 3'b100;
  localparam funct3_t F3_BGE  = 3'b101;
  localparam funct3_t F3_BLTU = 3'b110;
  localparam funct3_t F3_BGEU = 3'b111;

  typedef enum logic [2:0] {
    TYPE_R, TYPE_I, TYPE_S, TYPE_B, TYPE_U, TYPE_J, TYPE_NONE
  } instr_type_e;

  typedef enum logic [4:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLL,
    ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU, ALU_IMM
  } alu_op_e;

  typedef enum logic [1:0] {WD_ALU, WD_MEM, WD_LINK} wd_sel_e;
  typedef enum logic {SRC1_REG, SRC1_PC} src1_sel_e;
  typedef enum logic {SRC2_REG, SRC2_IMM} src2_sel_e;

endpackage

// ==== source/idu_pkg.sv ====
package idu_pkg;

  typedef struct packed {
    rv_isa_pkg::word_t instr;
    rv_isa_pkg::word_t pc;
  } fetch_t;

  // busy: result still pending, fwd_valid: result on the bus this cycle
  typedef struct packed {
    logic              busy;
    logic              fwd_valid;
    rv_isa_pkg::word_t result;
  } exu_status_t;

  typedef struct packed {
    logic                  busy;
    rv_isa_pkg::reg_addr_t rd;
  } lsu_status_t;

  typedef struct packed {
    logic                  wr_en;
    rv_isa_pkg::reg_addr_t rd;
    rv_isa_pkg::word_t     wd;
  } wbu_status_t;

  typedef struct packed {
    rv_isa_pkg::instr_type_e itype;
    rv_isa_pkg::alu_op_e     alu_op;
    rv_isa_pkg::src1_sel_e   src1_sel;
    rv_isa_pkg::src2_sel_e   src2_sel;
    rv_isa_pkg::wd_sel_e     wd_sel;
    logic                    reg_en;
    logic                    mem_ren;
    logic                    mem_wen;
    rv_isa_pkg::funct3_t     funct3;
    logic                    is_branch;
    logic                    is_jal;
    logic                    is_jalr;
  } dec_ctrl_t;

  typedef struct packed {
    rv_isa_pkg::word_t     pc;
    rv_isa_pkg::word_t     instr;
    rv_isa_pkg::word_t     src1;
    rv_isa_pkg::word_t     src2;
    rv_isa_pkg::word_t     rs2_val;
    rv_isa_pkg::word_t     imm;
    rv_isa_pkg::reg_addr_t rd;
    dec_ctrl_t             ctrl;
    rv_isa_pkg::word_t     pc_next;
  } issue_t;

endpackage

// ==== source/instr_decoder.sv ====
`timescale 1ns/1ps

module instr_decoder (
  input  rv_isa_pkg::word_t     instr_i,
  output idu_pkg::dec_ctrl_t    ctrl_o,
  output rv_isa_pkg::word_t     imm_o,
  output rv_isa_pkg::reg_addr_t rs1_o,
  output rv_isa_pkg::reg_addr_t rs2_o
);

  rv_isa_pkg::opcode_t opcode;
  rv_isa_pkg::funct3_t funct3;
  logic                alt;
  rv_isa_pkg::word_t   imm_i_type;
  rv_isa_pkg::word_t   imm_s_type;
  rv_isa_pkg::word_t   imm_b_type;
  rv_isa_pkg::word_t   imm_u_type;
  rv_isa_pkg::word_t   imm_j_type;

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  // funct7 bit 5, picks sub and sra
  assign alt    = instr_i[30];
  assign rs1_o  = instr_i[19:15];
  assign rs2_o  = instr_i[24:20];

  assign imm_i_type = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s_type = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_b_type = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                       instr_i[11:8], 1'b0};
  assign imm_u_type = {instr_i[31:12], 12'b0};
  assign imm_j_type = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                       instr_i[30:21], 1'b0};

  function automatic rv_isa_pkg::alu_op_e alu_from_f3(input rv_isa_pkg::funct3_t f3,
                                                      input logic f7_alt,
                                                      input logic sub_ok);
    case (f3)
      rv_isa_pkg::F3_ADD:  return (f7_alt && sub_ok) ? rv_isa_pkg::ALU_SUB : rv_isa_pkg::ALU_ADD;
      rv_isa_pkg::F3_SLL:  return rv_isa_pkg::ALU_SLL;
      rv_isa_pkg::F3_SLT:  return rv_isa_pkg::ALU_SLT;
      rv_isa_pkg::F3_SLTU: return rv_isa_pkg::ALU_SLTU;
      rv_isa_pkg::F3_XOR:  return rv_isa_pkg::ALU_XOR;
      rv_isa_pkg::F3_SR:   return f7_alt ? rv_isa_pkg::ALU_SRA : rv_isa_pkg::ALU_SRL;
      rv_isa_pkg::F3_OR:   return rv_isa_pkg::ALU_OR;
      default:             return rv_isa_pkg::ALU_AND;
    endcase
  endfunction

  always_comb begin
    ctrl_o           = '0;
    ctrl_o.itype     = rv_isa_pkg::TYPE_NONE;
    ctrl_o.alu_op    = rv_isa_pkg::ALU_ADD;
    ctrl_o.src1_sel  = rv_isa_pkg::SRC1_REG;
    ctrl_o.src2_sel  = rv_isa_pkg::SRC2_REG;
    ctrl_o.wd_sel    = rv_isa_pkg::WD_ALU;
    ctrl_o.funct3    = funct3;
    case (opcode)
      rv_isa_pkg::OPC_LUI: begin
        ctrl_o.itype    = rv_isa_pkg::TYPE_U;
        ctrl_o.alu_op   = rv_isa_pkg::ALU_IMM;
        ctrl_o.src2_sel = rv_isa_pkg::SRC2_IMM;
        ctrl_o.reg_en   = 1'b1;
      end
      rv_isa_pkg::OPC_AUIPC: begin
        ctrl_o.itype    = rv_isa_pkg::TYPE_U;
        ctrl_o.src1_sel = rv_isa_pkg::SRC1_PC;
        ctrl_o.src2_sel = rv_isa_pkg::SRC2_IMM;
        ctrl_o.reg_en   = 1'b1;
      end
      rv_isa_pkg::OPC_JAL: begin
        ctrl_o.itype    = rv_isa_pkg::TYPE_J;
        ctrl_o.src1_sel = rv_isa_pkg::SRC1_PC;
        ctrl_o.src2_sel = rv_isa_pkg::SRC2_IMM;
        ctrl_o.wd_sel   = rv_isa_pkg::WD_LINK;
        ctrl_o.reg_en   = 1'b1;
        ctrl_o.is_jal   = 1'b1;
      end
      rv_isa_pkg::OPC_JALR: begin
        ctrl_o.itype    = rv_isa_pkg::TYPE_I;
        ctrl_o.src2_sel = rv_isa_pkg::SRC2_IMM;
        ctrl_o.wd_sel   = rv_isa_pkg::WD_LINK;
        ctrl_o.reg_en   = 1'b1;
        ctrl_o.is_jalr  = 1'b1;
      end
      rv_isa_pkg::OPC_BRANCH: begin
        ctrl_o.itype     = rv_isa_pkg::TYPE_B;
        ctrl_o.is_branch = 1'b1;
        // equality via subtract, ordering via set-less-than
        case (funct3)
          rv_isa_pkg::F3_BLT, rv_isa_pkg::F3_BGE:   ctrl_o.alu_op = rv_isa_pkg::ALU_SLT;
          rv_isa_pkg::F3_BLTU, rv_isa_pkg::F3_BGEU: ctrl_o.alu_op = rv_isa_pkg::ALU_SLTU;
          default:                                  ctrl_o.alu_op = rv_isa_pkg::ALU_SUB;
        endcase
      end
      rv_isa_pkg::OPC_LOAD: begin
        ctrl_o.itype    = rv_isa_pkg::TYPE_I;
        ctrl_o.src2_sel = rv_isa_pkg::SRC2_IMM;
        ctrl_o.wd_sel   = rv_isa_pkg::WD_MEM;
        ctrl_o.reg_en   = 1'b1;
        ctrl_o.mem_ren  = 1'b1;
      end
      rv_isa_pkg::OPC_STORE: begin
        ctrl_o.itype    = rv_isa_pkg::TYPE_S;
        ctrl_o.src2_sel = rv_isa_pkg::SRC2_IMM;
        ctrl_o.mem_wen  = 1'b1;
      end
      rv_isa_pkg::OPC_OPIMM: begin
        ctrl_o.itype    = rv_isa_pkg::TYPE_I;
        ctrl_o.src2_sel = rv_isa_pkg::SRC2_IMM;
        ctrl_o.alu_op   = alu_from_f3(funct3, alt, 1'b0);
        ctrl_o.reg_en   = 1'b1;
      end
      rv_isa_pkg::OPC_OP: begin
        ctrl_o.itype  = rv_isa_pkg::TYPE_R;
        ctrl_o.alu_op = alu_from_f3(funct3, alt, 1'b1);
        ctrl_o.reg_en = 1'b1;
      end
      default: begin
      end
    endcase
  end

  always_comb begin
    case (ctrl_o.itype)
      rv_isa_pkg::TYPE_I: imm_o = imm_i_type;
      rv_isa_pkg::TYPE_S: imm_o = imm_s_type;
      rv_isa_pkg::TYPE_B: imm_o = imm_b_type;
      rv_isa_pkg::TYPE_U: imm_o = imm_u_type;
      rv_isa_pkg::TYPE_J: imm_o = imm_j_type;
      default:            imm_o = '0;
    endcase
  end

endmodule

// ==== source/operand_forward.sv ====
`timescale 1ns/1ps

module operand_forward (
  input  rv_isa_pkg::reg_addr_t rs1_i,
  input  rv_isa_pkg::reg_addr_t rs2_i,
  input  rv_isa_pkg::reg_addr_t issued_rd_i,
  input  logic                  issued_reg_en_i,
  input  logic                  issue_valid_i,
  input  idu_pkg::dec_ctrl_t    ctrl_i,
  input  rv_isa_pkg::word_t     imm_i,
  input  rv_isa_pkg::word_t     pc_i,
  input  rv_isa_pkg::word_t     rs1_data_i,
  input  rv_isa_pkg::word_t     rs2_data_i,
  input  idu_pkg::exu_status_t  exu_i,
  input  idu_pkg::lsu_status_t  lsu_i,
  input  idu_pkg::wbu_status_t  wbu_i,
  output rv_isa_pkg::word_t     src1_o,
  output rv_isa_pkg::word_t     src2_o,
  output rv_isa_pkg::word_t     rs2_val_o,
  output logic                  hazard_o
);

  // issue register content has been taken by execute and writes a register
  logic              exu_owns_rd;
  rv_isa_pkg::word_t fwd1;
  rv_isa_pkg::word_t fwd2;

  assign exu_owns_rd = issued_reg_en_i && !issue_valid_i;

  // execute first, then write-back, then register file
  function automatic rv_isa_pkg::word_t pick(input rv_isa_pkg::reg_addr_t rs,
                                             input rv_isa_pkg::word_t rf_data);
    if (rs != '0 && exu_owns_rd && exu_i.fwd_valid && rs == issued_rd_i) begin
      return exu_i.result;
    end else if (rs != '0 && wbu_i.wr_en && rs == wbu_i.rd) begin
      return wbu_i.wd;
    end
    return rf_data;
  endfunction

  function automatic logic reads_reg(input rv_isa_pkg::reg_addr_t rd);
    return (rd != '0) && (rd == rs1_i || rd == rs2_i);
  endfunction

  always_comb begin
    fwd1 = pick(rs1_i, rs1_data_i);
    fwd2 = pick(rs2_i, rs2_data_i);
  end

  assign src1_o    = (ctrl_i.src1_sel == rv_isa_pkg::SRC1_PC) ? pc_i : fwd1;
  assign src2_o    = (ctrl_i.src2_sel == rv_isa_pkg::SRC2_IMM) ? imm_i : fwd2;
  assign rs2_val_o = fwd2;

  always_comb begin
    hazard_o = (exu_i.busy && exu_owns_rd && reads_reg(issued_rd_i)) ||
               (lsu_i.busy && reads_reg(lsu_i.rd));
  end

endmodule

// ==== source/branch_resolve.sv ====
`timescale 1ns/1ps

module branch_resolve (
  input  rv_isa_pkg::word_t  pc_i,
  input  rv_isa_pkg::word_t  imm_i,
  input  rv_isa_pkg::word_t  src1_i,
  input  rv_isa_pkg::word_t  rs2_val_i,
  input  idu_pkg::dec_ctrl_t ctrl_i,
  output rv_isa_pkg::word_t  pc_next_o
);

  logic              taken;
  rv_isa_pkg::word_t jalr_target;

  always_comb begin
    case (ctrl_i.funct3)
      rv_isa_pkg::F3_BEQ:  taken = (src1_i == rs2_val_i);
      rv_isa_pkg::F3_BNE:  taken = (src1_i != rs2_val_i);
      rv_isa_pkg::F3_BLT:  taken = ($signed(src1_i) < $signed(rs2_val_i));
      rv_isa_pkg::F3_BGE:  taken = ($signed(src1_i) >= $signed(rs2_val_i));
      rv_isa_pkg::F3_BLTU: taken = (src1_i < rs2_val_i);
      rv_isa_pkg::F3_BGEU: taken = (src1_i >= rs2_val_i);
      default:             taken = 1'b0;
    endcase
  end

  // target must be halfword aligned
  assign jalr_target = (src1_i + imm_i) & ~rv_isa_pkg::word_t'(1);

  always_comb begin
    if (ctrl_i.is_jalr) begin
      pc_next_o = jalr_target;
    end else if (ctrl_i.is_jal || (ctrl_i.is_branch && taken)) begin
      pc_next_o = pc_i + imm_i;
    end else begin
      pc_next_o = pc_i + rv_isa_pkg::PC_STEP;
    end
  end

endmodule

// ==== source/issue_stage.sv ====
`timescale 1ns/1ps

module issue_stage (
  input  logic               clk,
  input  logic               rst,
  input  idu_pkg::fetch_t    fetch_i,
  input  logic               fetch_valid_i,
  output logic               fetch_ready_o,
  output idu_pkg::fetch_t    cur_o,
  input  logic               hazard_i,
  input  idu_pkg::dec_ctrl_t ctrl_i,
  input  rv_isa_pkg::word_t  imm_i,
  input  rv_isa_pkg::word_t  src1_i,
  input  rv_isa_pkg::word_t  src2_i,
  input  rv_isa_pkg::word_t  rs2_val_i,
  input  rv_isa_pkg::word_t  pc_next_i,
  output idu_pkg::issue_t    issue_o,
  output logic               issue_valid_o,
  input  logic               issue_ready_i
);

  typedef enum logic {ST_IDLE, ST_DECODE} state_e;

  state_e          state_q;
  state_e          state_d;
  idu_pkg::fetch_t buf_q;
  logic            buf_full_q;
  idu_pkg::fetch_t hold_q;
  logic            fetch_take;
  logic            issue_load;
  logic            issue_fire;

  assign fetch_ready_o = !buf_full_q;
  assign fetch_take    = fetch_valid_i && fetch_ready_o;
  assign issue_fire    = issue_valid_o && issue_ready_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (fetch_take || buf_full_q) begin
          state_d = ST_DECODE;
        end
      end
      ST_DECODE: begin
        if (issue_fire) begin
          state_d = ST_IDLE;
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  // a buffered word goes ahead of the fetch port
  assign cur_o = (state_q == ST_DECODE) ? hold_q : (buf_full_q ? buf_q : fetch_i);

  // one load per visit to DECODE
  assign issue_load = (state_d == ST_DECODE) && !issue_valid_o && !hazard_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q       <= ST_IDLE;
      buf_full_q    <= 1'b0;
      issue_valid_o <= 1'b0;
    end else begin
      state_q <= state_d;
      if (state_q == ST_DECODE && fetch_take) begin
        buf_full_q <= 1'b1;
      end else if (state_q == ST_IDLE && buf_full_q) begin
        buf_full_q <= 1'b0;
      end
      if (issue_load) begin
        issue_valid_o <= 1'b1;
      end else if (issue_fire) begin
        issue_valid_o <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == ST_DECODE && fetch_take) begin
      buf_q <= fetch_i;
    end
    // held so operands are re-read every stall cycle
    if (state_q == ST_IDLE && state_d == ST_DECODE) begin
      hold_q <= cur_o;
    end
    if (issue_load) begin
      issue_o.pc      <= cur_o.pc;
      issue_o.instr   <= cur_o.instr;
      issue_o.src1    <= src1_i;
      issue_o.src2    <= src2_i;
      issue_o.rs2_val <= rs2_val_i;
      issue_o.imm     <= imm_i;
      issue_o.rd      <= cur_o.instr[11:7];
      issue_o.ctrl    <= ctrl_i;
      issue_o.pc_next <= pc_next_i;
    end
  end

endmodule

// ==== source/idu_top.sv ====
`timescale 1ns/1ps

module idu_top (
  input  logic                  clk,
  input  logic                  rst,
  input  idu_pkg::fetch_t       fetch_i,
  input  logic                  fetch_valid_i,
  output logic                  fetch_ready_o,
  output rv_isa_pkg::reg_addr_t rs1_addr_o,
  output rv_isa_pkg::reg_addr_t rs2_addr_o,
  input  rv_isa_pkg::word_t     rs1_data_i,
  input  rv_isa_pkg::word_t     rs2_data_i,
  input  idu_pkg::exu_status_t  exu_status_i,
  input  idu_pkg::lsu_status_t  lsu_status_i,
  input  idu_pkg::wbu_status_t  wbu_status_i,
  output idu_pkg::issue_t       issue_o,
  output logic                  issue_valid_o,
  input  logic                  issue_ready_i
);

  idu_pkg::fetch_t    cur;
  idu_pkg::dec_ctrl_t ctrl;
  rv_isa_pkg::word_t  imm;
  rv_isa_pkg::word_t  src1;
  rv_isa_pkg::word_t  src2;
  rv_isa_pkg::word_t  rs2_val;
  rv_isa_pkg::word_t  pc_next;
  logic               hazard;

  issue_stage u_issue (
    .clk           (clk),
    .rst           (rst),
    .fetch_i       (fetch_i),
    .fetch_valid_i (fetch_valid_i),
    .fetch_ready_o (fetch_ready_o),
    .cur_o         (cur),
    .hazard_i      (hazard),
    .ctrl_i        (ctrl),
    .imm_i         (imm),
    .src1_i        (src1),
    .src2_i        (src2),
    .rs2_val_i     (rs2_val),
    .pc_next_i     (pc_next),
    .issue_o       (issue_o),
    .issue_valid_o (issue_valid_o),
    .issue_ready_i (issue_ready_i)
  );

  instr_decoder u_decoder (
    .instr_i (cur.instr),
    .ctrl_o  (ctrl),
    .imm_o   (imm),
    .rs1_o   (rs1_addr_o),
    .rs2_o   (rs2_addr_o)
  );

  // issued rd is the one execute is working on
  operand_forward u_forward (
    .rs1_i           (rs1_addr_o),
    .rs2_i           (rs2_addr_o),
    .issued_rd_i     (issue_o.rd),
    .issued_reg_en_i (issue_o.ctrl.reg_en),
    .issue_valid_i   (issue_valid_o),
    .ctrl_i          (ctrl),
    .imm_i           (imm),
    .pc_i            (cur.pc),
    .rs1_data_i      (rs1_data_i),
    .rs2_data_i      (rs2_data_i),
    .exu_i           (exu_status_i),
    .lsu_i           (lsu_status_i),
    .wbu_i           (wbu_status_i),
    .src1_o          (src1),
    .src2_o          (src2),
    .rs2_val_o       (rs2_val),
    .hazard_o        (hazard)
  );

  branch_resolve u_branch (
    .pc_i      (cur.pc),
    .imm_i     (imm),
    .src1_i    (src1),
    .rs2_val_i (rs2_val),
    .ctrl_i    (ctrl),
    .pc_next_o (pc_next)
  );

endmodule

// ==== bench/idu_tb.sv ====
`timescale 1ns/1ps

module idu_tb;

  localparam int NUM_REC     = 19;
  localparam int REC_W       = 14;
  localparam int CYCLE_LIMIT = 20 * NUM_REC + 10;

  logic                  clk;
  logic                  rst;
  idu_pkg::fetch_t       fetch_i;
  logic                  fetch_valid_i;
  logic                  fetch_ready_o;
  rv_isa_pkg::reg_addr_t rs1_addr_o;
  rv_isa_pkg::reg_addr_t rs2_addr_o;
  rv_isa_pkg::word_t     rs1_data_i;
  rv_isa_pkg::word_t     rs2_data_i;
  idu_pkg::exu_status_t  exu_status_i;
  idu_pkg::lsu_status_t  lsu_status_i;
  idu_pkg::wbu_status_t  wbu_status_i;
  idu_pkg::issue_t       issue_o;
  logic                  issue_valid_o;
  logic                  issue_ready_i;

  // per record: instr pc rs1d rs2d exu lsu wbu pc_next src1 src2 rd alu reg_en stall
  logic [39:0]       gold [0:NUM_REC*REC_W-1];
  rv_isa_pkg::word_t rec_rs1_data;
  rv_isa_pkg::word_t rec_rs2_data;
  int unsigned       lcg_state;
  int                cycles = 0;
  int                transfers = 0;

  idu_top uut (
    .clk           (clk),
    .rst           (rst),
    .fetch_i       (fetch_i),
    .fetch_valid_i (fetch_valid_i),
    .fetch_ready_o (fetch_ready_o),
    .rs1_addr_o    (rs1_addr_o),
    .rs2_addr_o    (rs2_addr_o),
    .rs1_data_i    (rs1_data_i),
    .rs2_data_i    (rs2_data_i),
    .exu_status_i  (exu_status_i),
    .lsu_status_i  (lsu_status_i),
    .wbu_status_i  (wbu_status_i),
    .issue_o       (issue_o),
    .issue_valid_o (issue_valid_o),
    .issue_ready_i (issue_ready_i)
  );

  // register file model that returns zero for x0
  assign rs1_data_i = (rs1_addr_o != '0 && rs1_addr_o == fetch_i.instr[19:15]) ?
                      rec_rs1_data : '0;
  assign rs2_data_i = (rs2_addr_o != '0 && rs2_addr_o == fetch_i.instr[24:20]) ?
                      rec_rs2_data : '0;

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic report_failure();
    $display("*** TEST FAILED ***");
    $fatal(1, "run stopped");
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (issue_valid_o && issue_ready_i) begin
      transfers <= transfers + 1;
    end
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      report_failure();
    end
  end

  function automatic int unsigned lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  task automatic check_word(input string name, input rv_isa_pkg::word_t exp,
                            input rv_isa_pkg::word_t act);
    if (exp !== act) begin
      $display("** Error %s expected %h actual %h", name, exp, act);
      report_failure();
    end
  endtask

  task automatic check_alu(input string name, input rv_isa_pkg::alu_op_e exp,
                           input rv_isa_pkg::alu_op_e act);
    if (exp !== act) begin
      $display("** Error %s expected %h actual %h", name, exp, act);
      report_failure();
    end
  endtask

  task automatic check_rd(input string name, input rv_isa_pkg::reg_addr_t exp,
                          input rv_isa_pkg::reg_addr_t act);
    if (exp !== act) begin
      $display("** Error %s expected %h actual %h", name, exp, act);
      report_failure();
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      $display("** Error %s expected %h actual %h", name, exp, act);
      report_failure();
    end
  endtask

  // starts at a negedge and counts the extra cycles spent
  task automatic wait_issue(output int waited);
    waited = 0;
    while (issue_valid_o !== 1'b1) begin
      @(negedge clk);
      waited++;
    end
  endtask

  initial begin
    int              b;
    int              gap;
    int              waited;
    idu_pkg::issue_t snap;
    $readmemh("bench/idu_golden.hex", gold);
    lcg_state = 13301;
    rst           <= 1'b1;
    fetch_i       <= '0;
    fetch_valid_i <= 1'b0;
    exu_status_i  <= '0;
    lsu_status_i  <= '0;
    wbu_status_i  <= '0;
    issue_ready_i <= 1'b0;
    rec_rs1_data  <= '0;
    rec_rs2_data  <= '0;
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check_bit("fetch_ready_o", 1'b1, fetch_ready_o);
    check_bit("issue_valid_o", 1'b0, issue_valid_o);

    for (int r = 0; r < NUM_REC; r++) begin
      b = r * REC_W;
      @(posedge clk);
      fetch_i       <= idu_pkg::fetch_t'({gold[b][31:0], gold[b+1][31:0]});
      rec_rs1_data  <= gold[b+2][31:0];
      rec_rs2_data  <= gold[b+3][31:0];
      exu_status_i  <= idu_pkg::exu_status_t'(gold[b+4][33:0]);
      lsu_status_i  <= idu_pkg::lsu_status_t'(gold[b+5][5:0]);
      wbu_status_i  <= idu_pkg::wbu_status_t'(gold[b+6][37:0]);
      fetch_valid_i <= 1'b1;
      @(posedge clk);
      fetch_valid_i <= 1'b0;

      if (gold[b+13][0]) begin
        repeat (3) begin
          @(negedge clk);
          check_bit("issue_valid_o", 1'b0, issue_valid_o);
        end
        @(posedge clk);
        exu_status_i.busy <= 1'b0;
        lsu_status_i.busy <= 1'b0;
      end
      @(negedge clk);
      wait_issue(waited);
      if (gold[b+13][0] && waited > 1) begin
        $display("stall did not end one cycle after busy was dropped");
        report_failure();
      end else if (!gold[b+13][0] && waited != 0) begin
        $display("issue_valid_o did not rise one cycle after the fetch was taken");
        report_failure();
      end

      // random back-pressure before the handshake
      snap = issue_o;
      gap  = int'((lcg_next() >> 16) % 4);
      repeat (gap) begin
        @(negedge clk);
        check_bit("issue_valid_o", 1'b1, issue_valid_o);
        check_word("issue_o.pc_next", snap.pc_next, issue_o.pc_next);
        check_word("issue_o.src1", snap.src1, issue_o.src1);
        check_word("issue_o.src2", snap.src2, issue_o.src2);
        check_word("issue_o.instr", snap.instr, issue_o.instr);
        check_word("issue_o.pc", snap.pc, issue_o.pc);
        check_word("issue_o.rs2_val", snap.rs2_val, issue_o.rs2_val);
        check_word("issue_o.imm", snap.imm, issue_o.imm);
        check_rd("issue_o.rd", snap.rd, issue_o.rd);
        check_alu("issue_o.ctrl.alu_op", snap.ctrl.alu_op, issue_o.ctrl.alu_op);
        check_bit("issue_o.ctrl.reg_en", snap.ctrl.reg_en, issue_o.ctrl.reg_en);
      end
      @(posedge clk);
      issue_ready_i <= 1'b1;
      @(negedge clk);
      check_bit("issue_valid_o", 1'b1, issue_valid_o);
      check_word("issue_o.instr", gold[b][31:0], issue_o.instr);
      check_word("issue_o.pc", gold[b+1][31:0], issue_o.pc);
      check_word("issue_o.pc_next", gold[b+7][31:0], issue_o.pc_next);
      check_word("issue_o.src1", gold[b+8][31:0], issue_o.src1);
      check_word("issue_o.src2", gold[b+9][31:0], issue_o.src2);
      check_rd("issue_o.rd", rv_isa_pkg::reg_addr_t'(gold[b+10][4:0]), issue_o.rd);
      check_alu("issue_o.ctrl.alu_op", rv_isa_pkg::alu_op_e'(gold[b+11][4:0]),
                issue_o.ctrl.alu_op);
      check_bit("issue_o.ctrl.reg_en", gold[b+12][0], issue_o.ctrl.reg_en);
      @(posedge clk);
      issue_ready_i <= 1'b0;
      @(negedge clk);
      check_bit("issue_valid_o", 1'b0, issue_valid_o);
    end

    check_word("transfers", rv_isa_pkg::word_t'(NUM_REC), rv_isa_pkg::word_t'(transfers));
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

// ==== bench/idu_golden.hex ====
// instr pc rs1_data rs2_data exu lsu wbu | exp: pc_next src1 src2 rd alu_op reg_en stall
// exu = {busy, fwd_valid, result}, lsu = {busy, rd}, wbu = {wr_en, rd, wd}
002081B3 00000100 11111111 22222222 0 00 0 00000104 11111111 22222222 03 0 1 0
404182B3 00000104 33333333 44444444 1AAAA0000 00 23BBBB0000 00000108 AAAA0000 44444444 05 1 1 0
00524333 00000108 44444444 55555555 155550000 00 240000CCCC 0000010C 0000CCCC 55550000 06 4 1 0
006063B3 0000010C 00000000 66666666 166660000 00 20DEADBEEF 00000110 00000000 66660000 07 3 1 0
FFF38413 00000110 77777777 00000000 0 00 0 00000114 77777777 FFFFFFFF 08 0 1 0
40345493 00000114 88888888 00000000 0 00 0 00000118 88888888 00000403 09 7 1 0
12345537 00000118 00000000 00000000 0 00 0 0000011C 00000000 12345000 0A A 1 0
00001597 0000011C 00000000 00000000 0 00 0 00000120 0000011C 00001000 0B 0 1 0
00812603 00000120 00002000 00000000 0 22 0 00000124 00002000 00000008 0C 0 1 1
00C2A223 00000124 50000000 0C0C0C0C 112120000 00 0 00000128 50000000 00000004 04 0 0 0
00208463 00000200 00000005 00000005 0 00 0 00000208 00000005 00000005 08 1 0 0
00209463 00000208 00000005 00000005 0 00 0 0000020C 00000005 00000005 08 1 0 0
FE20CCE3 00000300 FFFFFFFF 00000001 0 00 0 000002F8 FFFFFFFF 00000001 19 8 0 0
FE20DCE3 00000300 FFFFFFFF 00000001 0 00 0 00000304 FFFFFFFF 00000001 19 8 0 0
FE20ECE3 00000300 FFFFFFFF 00000001 0 00 0 00000304 FFFFFFFF 00000001 19 9 0 0
FE20FCE3 00000300 FFFFFFFF 00000001 0 00 0 000002F8 FFFFFFFF 00000001 19 9 0 0
010000EF 00000400 00000000 00000000 0 00 0 00000410 00000400 00000010 01 0 1 0
003302E7 00000410 00001000 00000000 0 00 0 00001002 00001000 00000003 05 0 1 0
000283B3 00000500 55555555 00000000 377770000 00 0 00000504 77770000 00000000 07 0 1 1

// ==== flist.f ====
source/rv_isa_pkg.sv
source/idu_pkg.sv
source/instr_decoder.sv
source/operand_forward.sv
source/branch_resolve.sv
source/issue_stage.sv
source/idu_top.sv
bench/idu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f flist.f --top-module idu_tb -Mdir obj_dir -o idu_sim
./obj_dir/idu_sim > sim.log 2>&1
cat sim.log

if grep -qF "*** TEST PASSED ***" sim.log; then
  exit 0
else
  exit 1
fi
